// ==== source/display_pkg.sv ====
/*
 * display package
 * 720p raster timing, screen layout, palette and the structs that carry
 * pixel position, sync and bar samples between the pipeline stages
 */
`default_nettype none

package display_pkg;

    // ======================================================================
    // types
    // ======================================================================
    typedef logic [11:0] coord_t;       // screen coordinate or counter
    typedef logic [23:0] rgb_t;         // red in [23:16], blue in [7:0]
    typedef logic [9:0]  bin_addr_t;    // spectrum bin address

    typedef struct packed {
        coord_t x;
        coord_t y;
        logic   active;
    } pixel_pos_t;

    typedef struct packed {
        logic hs;
        logic vs;
    } raster_sync_t;

    typedef struct packed {
        coord_t height;     // bar height in lines
        rgb_t   grade;      // colour picked from the height
    } bar_sample_t;

    // ======================================================================
    // 1280x720 timing, positive sync polarity
    // ======================================================================
    localparam int H_ACTIVE = 1280;
    localparam int H_FP     = 110;
    localparam int H_SYNC   = 40;
    localparam int H_BP     = 220;
    localparam int H_TOTAL  = 1650;

    localparam int V_ACTIVE = 720;
    localparam int V_FP     = 5;
    localparam int V_SYNC   = 5;
    localparam int V_BP     = 20;
    localparam int V_TOTAL  = 750;

    // screen layout, in active coordinates
    localparam coord_t TITLE_END    = 12'd50;
    localparam coord_t SPECTRUM_END = 12'd550;
    localparam coord_t FOOTER_START = 12'd580;
    localparam coord_t GRID_X       = 12'd100;
    localparam coord_t GRID_Y       = 12'd50;
    localparam coord_t BAR_MAX      = 12'd480;   // clamp for saturated bins
    localparam coord_t BAR_LIMIT    = 12'd2000;  // bin value that saturates
    localparam coord_t BAR_LIFT     = 12'd10;    // bars start above the floor

    // palette
    localparam rgb_t COL_FRAME  = 24'h4080FF;
    localparam rgb_t COL_TITLE  = 24'h1A1A2E;
    localparam rgb_t COL_GRID   = 24'h303030;
    localparam rgb_t COL_SEP    = 24'h0F0F23;
    localparam rgb_t COL_DIM    = 24'h404040;
    localparam rgb_t COL_GREEN  = 24'h00FF00;
    localparam rgb_t COL_RED    = 24'hFF0000;
    localparam rgb_t COL_YELLOW = 24'hFFFF00;
    localparam rgb_t COL_CYAN   = 24'h00FFFF;
    localparam rgb_t COL_LOW    = 24'h0080FF;
    localparam rgb_t COL_BLACK  = 24'h000000;
    localparam rgb_t COL_BG     = 24'h101014;   // spectrum background base

endpackage

`default_nettype wire

// ==== source/raster_timing.sv ====
/*
 * raster timing
 * 1650x750 horizontal and vertical counters for 720p, registered sync,
 * active flag and active-area pixel coordinates
 */
`default_nettype none

module raster_timing (
    input  wire logic                  clk_pixel,
    input  wire logic                  rst_n,
    output display_pkg::pixel_pos_t    pos,
    output display_pkg::raster_sync_t  sync
);

    import display_pkg::*;

    localparam coord_t H_START = coord_t'(H_SYNC + H_BP);
    localparam coord_t H_STOP  = coord_t'(H_TOTAL - H_FP);
    localparam coord_t V_START = coord_t'(V_SYNC + V_BP);
    localparam coord_t V_STOP  = coord_t'(V_TOTAL - V_FP);

    coord_t h_cnt;
    coord_t v_cnt;
    logic   h_wrap;
    logic   h_active;
    logic   v_active;

    assign h_wrap   = (h_cnt == coord_t'(H_TOTAL - 1));
    assign h_active = (h_cnt >= H_START) && (h_cnt < H_STOP);
    assign v_active = (v_cnt >= V_START) && (v_cnt < V_STOP);

    // ======================================================================
    // counters
    // ======================================================================
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            h_cnt <= '0;
        end else if (h_wrap) begin
            h_cnt <= '0;
        end else begin
            h_cnt <= h_cnt + 12'd1;
        end
    end

    // line counter only moves at the end of a line
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            v_cnt <= '0;
        end else if (h_wrap) begin
            if (v_cnt == coord_t'(V_TOTAL - 1)) begin
                v_cnt <= '0;
            end else begin
                v_cnt <= v_cnt + 12'd1;
            end
        end
    end

    // ======================================================================
    // registered sync, active flag and coordinates
    // ======================================================================
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            sync <= '0;
        end else begin
            sync.hs <= (h_cnt < coord_t'(H_SYNC));   // positive polarity
            sync.vs <= (v_cnt < coord_t'(V_SYNC));
        end
    end

    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            pos <= '0;
        end else begin
            pos.active <= h_active && v_active;
            pos.x      <= h_active ? (h_cnt - H_START) : '0;
            pos.y      <= v_active ? (v_cnt - V_START) : '0;
        end
    end

    // frame starts only on a line boundary
    a_vs_on_line_wrap : assert property (
        @(posedge clk_pixel) disable iff (!rst_n)
        $rose(sync.vs) |-> ($past(h_cnt) == '0)
    );

    // sync pulse sits in blanking
    a_no_active_in_hs : assert property (
        @(posedge clk_pixel) disable iff (!rst_n)
        !(pos.active && sync.hs)
    );

endmodule

`default_nettype wire

// ==== source/spectrum_column.sv ====
/*
 * spectrum column
 * maps the pixel column to a spectrum bin address, scales the returned
 * bin value to a bar height and grades its colour
 */
`default_nettype none

module spectrum_column (
    input  wire logic                  clk_pixel,
    input  wire logic                  rst_n,
    input  wire display_pkg::pixel_pos_t pos,
    output display_pkg::bin_addr_t     spectrum_addr,
    input  wire logic [15:0]           spectrum_data,
    output display_pkg::bar_sample_t   bar
);

    import display_pkg::*;

    coord_t height_next;
    rgb_t   grade_next;

    // ======================================================================
    // bin addressing
    // ======================================================================
    // four pixels per bin, parked on the last bin during blanking
    always_comb begin
        if (pos.active) begin
            spectrum_addr = pos.x[11:2];
        end else begin
            spectrum_addr = '1;
        end
    end

    // ======================================================================
    // height scaling and grading
    // ======================================================================
    // word arrives one clock after the address
    always_comb begin
        if (spectrum_data > {4'd0, BAR_LIMIT}) begin
            height_next = BAR_MAX;             // saturated bin
        end else begin
            height_next = spectrum_data[15:4];
        end
    end

    always_comb begin
        if (height_next > 12'd400) begin
            grade_next = COL_RED;
        end else if (height_next > 12'd300) begin
            grade_next = COL_YELLOW;
        end else if (height_next > 12'd200) begin
            grade_next = COL_GREEN;
        end else if (height_next > 12'd100) begin
            grade_next = COL_CYAN;
        end else begin
            grade_next = COL_LOW;              // quiet bins stay blue
        end
    end

    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            bar <= '0;
        end else begin
            bar.height <= height_next;
            bar.grade  <= grade_next;
        end
    end

    // clamp keeps the bar inside the spectrum area
    a_height_clamped : assert property (
        @(posedge clk_pixel) disable iff (!rst_n)
        bar.height <= BAR_MAX
    );

endmodule

`default_nettype wire

// ==== source/screen_painter.sv ====
/*
 * screen painter
 * lines up position and sync with the bar sample, picks the colour of
 * each active pixel by screen region and registers the video outputs
 */
`default_nettype none

module screen_painter (
    input  wire logic                    clk_pixel,
    input  wire logic                    rst_n,
    input  wire display_pkg::pixel_pos_t   pos,
    input  wire display_pkg::raster_sync_t sync,
    input  wire logic                    current_channel,
    input  wire display_pkg::bar_sample_t  bar,
    output display_pkg::rgb_t            rgb_out,
    output logic                         de_out,
    output logic                         hs_out,
    output logic                         vs_out
);

    import display_pkg::*;

    pixel_pos_t   pos_d1;
    pixel_pos_t   pos_d2;
    raster_sync_t sync_d1;
    raster_sync_t sync_d2;
    coord_t       px;
    coord_t       py;
    coord_t       bar_top;
    logic         on_grid;
    logic         side_border;
    rgb_t         rgb_next;

    // ======================================================================
    // alignment with the bar sample
    // ======================================================================
    // two stages match the address and memory read path
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            pos_d1  <= '0;
            pos_d2  <= '0;
            sync_d1 <= '0;
            sync_d2 <= '0;
        end else begin
            pos_d1  <= pos;
            pos_d2  <= pos_d1;
            sync_d1 <= sync;
            sync_d2 <= sync_d1;
        end
    end

    assign px          = pos_d2.x;
    assign py          = pos_d2.y;
    assign bar_top     = SPECTRUM_END - BAR_LIFT - bar.height;
    assign on_grid     = ((px % GRID_X) == '0) || ((py % GRID_Y) == '0);
    assign side_border = (px < 12'd2) || (px >= coord_t'(H_ACTIVE - 2));

    // ======================================================================
    // region decode
    // ======================================================================
    always_comb begin
        rgb_next = COL_BLACK;
        if (pos_d2.active) begin
            if (py < TITLE_END) begin
                // title bar with its own frame
                if (px < 12'd5 || px >= coord_t'(H_ACTIVE - 5) ||
                    py < 12'd2 || py >= TITLE_END - 12'd2) begin
                    rgb_next = COL_FRAME;
                end else begin
                    rgb_next = COL_TITLE;
                end
                // channel indicator blocks, lit one at a time
                if (py >= 12'd15 && py < 12'd35) begin
                    if (px >= 12'd20 && px < 12'd120) begin
                        rgb_next = current_channel ? COL_DIM : COL_GREEN;
                    end else if (px >= 12'd140 && px < 12'd240) begin
                        rgb_next = current_channel ? COL_RED : COL_DIM;
                    end
                end
            end else if (py < SPECTRUM_END) begin
                if (on_grid) begin
                    rgb_next = COL_GRID;
                end else if (py >= bar_top) begin
                    rgb_next = bar.grade;
                end else begin
                    rgb_next = COL_BG + rgb_t'(py[8:6]);   // faint blue ramp
                end
            end else if (py < FOOTER_START) begin
                if (py == SPECTRUM_END || py == FOOTER_START - 12'd1) begin
                    rgb_next = COL_FRAME;   // separator edges
                end else begin
                    rgb_next = COL_SEP;
                end
            end else if (py >= coord_t'(V_ACTIVE - 2)) begin
                rgb_next = COL_FRAME;       // bottom border
            end

            // side borders win over every region
            if (side_border) begin
                rgb_next = COL_FRAME;
            end
        end
    end

    // ======================================================================
    // output registers
    // ======================================================================
    always_ff @(posedge clk_pixel or negedge rst_n) begin
        if (!rst_n) begin
            rgb_out <= COL_BLACK;
            de_out  <= 1'b0;
            hs_out  <= 1'b0;
            vs_out  <= 1'b0;
        end else begin
            rgb_out <= rgb_next;
            de_out  <= pos_d2.active;
            hs_out  <= sync_d2.hs;
            vs_out  <= sync_d2.vs;
        end
    end

endmodule

`default_nettype wire

// ==== source/hdmi_display_ctrl.sv ====
/*
 * hdmi display controller
 * 720p frame generator for the two-channel spectrum view
 * chain is raster timing, spectrum column, screen painter
 */
`default_nettype none

module hdmi_display_ctrl (
    input  wire logic                clk_pixel,
    input  wire logic                rst_n,
    input  wire logic [15:0]         spectrum_data,
    output wire display_pkg::bin_addr_t spectrum_addr,
    input  wire logic                current_channel,
    output wire display_pkg::rgb_t   rgb_out,
    output wire logic                de_out,
    output wire logic                hs_out,
    output wire logic                vs_out
);

    import display_pkg::*;

    pixel_pos_t   pos;     // one cycle behind the counters
    raster_sync_t sync;
    bar_sample_t  bar;     // two cycles behind pos

    raster_timing u_raster_timing (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n),
        .pos       (pos),
        .sync      (sync)
    );

    spectrum_column u_spectrum_column (
        .clk_pixel     (clk_pixel),
        .rst_n         (rst_n),
        .pos           (pos),
        .spectrum_addr (spectrum_addr),
        .spectrum_data (spectrum_data),
        .bar           (bar)
    );

    // outputs land 4 cycles after the counters
    screen_painter u_screen_painter (
        .clk_pixel       (clk_pixel),
        .rst_n           (rst_n),
        .pos             (pos),
        .sync            (sync),
        .current_channel (current_channel),
        .bar             (bar),
        .rgb_out         (rgb_out),
        .de_out          (de_out),
        .hs_out          (hs_out),
        .vs_out          (vs_out)
    );

endmodule

`default_nettype wire

// ==== verification/tb_clock_gen.sv ====
/*
 * testbench clock and reset
 * free-running pixel clock and an active-low reset held for a set
 * number of cycles, released on a falling edge
 */
`default_nettype none

module tb_clock_gen #(
    parameter int HALF_PERIOD  = 4,     // 8 unit period
    parameter int RESET_CYCLES = 16
) (
    output logic clk_pixel,
    output logic rst_n
);

    initial begin
        clk_pixel = 1'b0;
        forever #HALF_PERIOD clk_pixel = ~clk_pixel;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_pixel);
        @(negedge clk_pixel);
        rst_n = 1'b1;   // released away from the rising edge
    end

endmodule

`default_nettype wire

// ==== verification/tb_hdmi_display_ctrl.sv ====
/*
 * testbench for the hdmi display controller
 * spectrum memory model, line and frame timing monitors, and a probe
 * table of pixel colours checked over two frames, one per channel
 */
`default_nettype none

module tb_hdmi_display_ctrl;

    // 720p raster as seen on the outputs
    localparam int H_ACTIVE = 1280;
    localparam int H_SYNC   = 40;
    localparam int H_BP     = 220;
    localparam int H_TOTAL  = 1650;
    localparam int V_ACTIVE = 720;
    localparam int V_SYNC   = 5;
    localparam int V_BP     = 20;
    localparam int V_TOTAL  = 750;
    localparam int TIMEOUT_CYCLES = 2 * H_TOTAL * V_TOTAL + 2000;

    logic        clk_pixel;
    logic        rst_n;
    logic [15:0] spectrum_data = 16'd0;
    logic [9:0]  spectrum_addr;
    logic        current_channel;
    logic [23:0] rgb_out;
    logic        de_out;
    logic        hs_out;
    logic        vs_out;

    int error_count = 0;
    int check_count = 0;

    // probe table, one column per queue
    string probe_name[$];
    int    probe_x[$];
    int    probe_y[$];
    int    probe_ch[$];
    int    probe_rgb[$];

    int   pix_cnt;
    int   frame_idx;
    int   probe_idx;
    logic vs_last;
    int   timeout_cnt;

    logic [9:0] addr_hist [3];      // addresses of the last three cycles
    int         addr_seen;
    logic [9:0] addr_held = '1;

    tb_clock_gen u_tb_clock_gen (
        .clk_pixel (clk_pixel),
        .rst_n     (rst_n)
    );

    hdmi_display_ctrl u_hdmi_display_ctrl (
        .clk_pixel       (clk_pixel),
        .rst_n           (rst_n),
        .spectrum_data   (spectrum_data),
        .spectrum_addr   (spectrum_addr),
        .current_channel (current_channel),
        .rgb_out         (rgb_out),
        .de_out          (de_out),
        .hs_out          (hs_out),
        .vs_out          (vs_out)
    );

    // ======================================================================
    // helpers
    // ======================================================================
    task automatic check_value(input string name, input int expected, input int actual);
        check_count++;
        if (expected != actual) begin
            error_count++;
            $display("FAILED %s: expected %0h, actual %0h", name, expected, actual);
        end
    endtask

    // bin contents, bin 200 pushed past saturation
    function automatic logic [15:0] bin_word(input logic [9:0] addr);
        logic [15:0] word;
        word = 16'(addr) * 16'd3;
        if (addr == 10'd200) begin
            word = word + 16'd3000;
        end
        return word;
    endfunction

    task automatic add_probe(input string name, input int x, input int y,
                             input int ch, input int rgb);
        probe_name.push_back(name);
        probe_x.push_back(x);
        probe_y.push_back(y);
        probe_ch.push_back(ch);
        probe_rgb.push_back(rgb);
    endtask

    // raster order within each frame
    task automatic load_probes();
        // frame 1, channel 0
        add_probe("title frame top",       600,   1, 0, 24'h4080FF);
        add_probe("title frame left",        3,  20, 0, 24'h4080FF);
        add_probe("ch0 block 1 lit",        60,  25, 0, 24'h00FF00);
        add_probe("ch0 block 2 dim",       200,  25, 0, 24'h404040);
        add_probe("title background",      600,  25, 0, 24'h1A1A2E);
        add_probe("side border title",    1279,  25, 0, 24'h4080FF);
        add_probe("title frame bottom",    600,  49, 0, 24'h4080FF);
        add_probe("grid column",           300,  77, 0, 24'h303030);
        add_probe("grid row",              123, 150, 0, 24'h303030);
        add_probe("grid crossing",         100, 200, 0, 24'h303030);
        add_probe("low bin background",     50, 310, 0, 24'h101018);
        add_probe("low bin bar",            50, 545, 0, 24'h0080FF);
        // frame 2, channel 1
        add_probe("ch1 block 1 dim",        60,  25, 1, 24'h404040);
        add_probe("ch1 block 2 lit",       200,  25, 1, 24'hFF0000);
        add_probe("saturated bin above",   801,  59, 1, 24'h101014);
        add_probe("saturated bin bar",     801,  61, 1, 24'hFF0000);
        add_probe("side border left",        0, 300, 1, 24'h4080FF);
        add_probe("separator top line",    640, 550, 1, 24'h4080FF);
        add_probe("separator background",  640, 565, 1, 24'h0F0F23);
        add_probe("separator bottom line", 640, 579, 1, 24'h4080FF);
        add_probe("side border footer",   1278, 600, 1, 24'h4080FF);
        add_probe("footer black",          640, 650, 1, 24'h000000);
        add_probe("bottom border 718",     640, 718, 1, 24'h4080FF);
        add_probe("bottom border 719",     640, 719, 1, 24'h4080FF);
    endtask

    // registered read, word for last cycle's address driven mid-cycle
    always @(negedge clk_pixel) begin
        spectrum_data <= bin_word(addr_held);
        addr_held     <= spectrum_addr;
    end

    // ======================================================================
    // line and frame timing monitors
    // ======================================================================
    int   cyc = 0;
    int   hs_rise_at = 0;
    int   de_rise_at = 0;
    int   vs_rise_at = 0;
    int   lines_in_frame = 0;
    int   frames_timed = 0;
    logic hs_prev = 1'b0;
    logic de_prev = 1'b0;
    logic vs_prev = 1'b0;
    logic hs_seen = 1'b0;
    logic vs_seen = 1'b0;

    always @(negedge clk_pixel) begin
        cyc = cyc + 1;
        if (hs_out && !hs_prev) begin
            if (hs_seen) begin
                check_value("hs period", H_TOTAL, cyc - hs_rise_at);
            end
            hs_rise_at = cyc;
            hs_seen    = 1'b1;
        end
        if (!hs_out && hs_prev) begin
            check_value("hs width", H_SYNC, cyc - hs_rise_at);
        end
        if (de_out && !de_prev) begin
            check_value("de start after hs", H_SYNC + H_BP, cyc - hs_rise_at);
            if (vs_seen && lines_in_frame == 0) begin
                check_value("first de line after vs",
                            (V_SYNC + V_BP) * H_TOTAL + H_SYNC + H_BP, cyc - vs_rise_at);
            end
            de_rise_at     = cyc;
            lines_in_frame = lines_in_frame + 1;
        end
        if (!de_out && de_prev) begin
            check_value("de width", H_ACTIVE, cyc - de_rise_at);
        end
        if (vs_out && !vs_prev) begin
            if (vs_seen) begin
                check_value("de lines per frame", V_ACTIVE, lines_in_frame);
                frames_timed = frames_timed + 1;
            end
            lines_in_frame = 0;
            vs_rise_at     = cyc;
            vs_seen        = 1'b1;
        end
        if (!vs_out && vs_prev) begin
            check_value("vs width", V_SYNC * H_TOTAL, cyc - vs_rise_at);
        end
        hs_prev = hs_out;
        de_prev = de_out;
        vs_prev = vs_out;
    end

    // ======================================================================
    // main sequence
    // ======================================================================
    initial begin
        current_channel = 1'b0;
        load_probes();

        // rst_n only moves on falling edges
        while (rst_n !== 1'b1) begin
            @(posedge clk_pixel);
            if (rst_n === 1'b0) begin
                check_value("reset hs_out", 0, int'(hs_out));
                check_value("reset vs_out", 0, int'(vs_out));
                check_value("reset de_out", 0, int'(de_out));
                check_value("reset rgb_out", 0, int'(rgb_out));
            end
        end

        pix_cnt   = 0;
        frame_idx = -1;
        probe_idx = 0;
        vs_last   = 1'b0;
        addr_seen = 0;
        while (frame_idx < 2) begin
            @(negedge clk_pixel);
            if (vs_out && !vs_last) begin
                frame_idx       = frame_idx + 1;
                pix_cnt         = 0;
                current_channel = frame_idx[0];   // switched in vertical blanking
            end
            vs_last = vs_out;

            // the bin of a pixel is addressed 3 cycles before its colour
            if (addr_seen >= 3) begin
                if (de_out) begin
                    check_value("spectrum_addr for pixel",
                                (pix_cnt % H_ACTIVE) / 4, int'(addr_hist[2]));
                end else begin
                    check_value("spectrum_addr in blanking", 1023, int'(addr_hist[2]));
                end
            end
            addr_hist[2] = addr_hist[1];
            addr_hist[1] = addr_hist[0];
            addr_hist[0] = spectrum_addr;
            addr_seen    = addr_seen + 1;

            if (de_out && frame_idx >= 0 && frame_idx < 2) begin
                while (probe_idx < probe_x.size() && probe_ch[probe_idx] == frame_idx &&
                       probe_y[probe_idx] * H_ACTIVE + probe_x[probe_idx] == pix_cnt) begin
                    check_value(probe_name[probe_idx], probe_rgb[probe_idx], int'(rgb_out));
                    probe_idx = probe_idx + 1;
                end
                pix_cnt = pix_cnt + 1;
            end
        end
        repeat (2) @(negedge clk_pixel);   // let the monitors finish this edge

        if (probe_idx != probe_x.size()) begin
            error_count++;
            $display("probe %0d was never reached in its frame", probe_idx);
        end
        if (frames_timed == 0) begin
            error_count++;
            $display("no complete frame was seen by the timing monitor");
        end

        $display("checks: %0d, errors: %0d", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // two frames plus reset and pipeline fill
    initial begin
        timeout_cnt = 0;
        while (timeout_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk_pixel);
            timeout_cnt = timeout_cnt + 1;
        end
        $display("timeout after %0d cycles, two frames did not complete", timeout_cnt);
        $display("Simulation finished: FAIL");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
source/display_pkg.sv
source/raster_timing.sv
source/spectrum_column.sv
source/screen_painter.sv
source/hdmi_display_ctrl.sv
verification/tb_clock_gen.sv
verification/tb_hdmi_display_ctrl.sv

// ==== Makefile ====
# Verilator build and run for the hdmi display controller testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_hdmi_display_ctrl
FILELIST  := compile.f
OBJ_DIR   := obj_dir
LOG       := sim.log
FAIL_MSG  := Simulation finished: FAIL
PASS_MSG  := Simulation finished: PASS

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG) || ! grep -q "$(PASS_MSG)" $(LOG); then \
		echo "test failed"; exit 1; fi
	@echo "test passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
